// ==== common/csr_addr_pkg.sv ====
package csr_addr_pkg;

    localparam int CSR_NUM_W  = 14;
    localparam int CSR_DATA_W = 32;

    // register numbers
    localparam logic [CSR_NUM_W-1:0] CSR_CRMD   = 14'h0;
    localparam logic [CSR_NUM_W-1:0] CSR_PRMD   = 14'h1;
    localparam logic [CSR_NUM_W-1:0] CSR_ECFG   = 14'h4;
    localparam logic [CSR_NUM_W-1:0] CSR_ESTAT  = 14'h5;
    localparam logic [CSR_NUM_W-1:0] CSR_ERA    = 14'h6;
    localparam logic [CSR_NUM_W-1:0] CSR_BADV   = 14'h7;
    localparam logic [CSR_NUM_W-1:0] CSR_EENTRY = 14'hc;
    localparam logic [CSR_NUM_W-1:0] CSR_SAVE0  = 14'h30;
    localparam logic [CSR_NUM_W-1:0] CSR_SAVE1  = 14'h31;
    localparam logic [CSR_NUM_W-1:0] CSR_SAVE2  = 14'h32;
    localparam logic [CSR_NUM_W-1:0] CSR_SAVE3  = 14'h33;
    localparam logic [CSR_NUM_W-1:0] CSR_TCFG   = 14'h41;
    localparam logic [CSR_NUM_W-1:0] CSR_TVAL   = 14'h42;
    localparam logic [CSR_NUM_W-1:0] CSR_TICLR  = 14'h44;

    // eentry bits below this read zero
    localparam int EENTRY_VA_LSB      = 6;
    localparam int TCFG_INITVAL_LSB   = 2;
    localparam int ESTAT_ECODE_LSB    = 16;
    localparam int ESTAT_ESUBCODE_LSB = 22;

    // implemented bits of the mode registers
    localparam int CRMD_W = 9;
    localparam int PRMD_W = 3;

endpackage

// ==== common/csr_exc_pkg.sv ====
package csr_exc_pkg;

    localparam int ECODE_W    = 6;
    localparam int ESUBCODE_W = 9;

    // ade with esubcode 0 is a fetch address error
    localparam logic [ECODE_W-1:0] ECODE_ADE = 6'h8;
    localparam logic [ECODE_W-1:0] ECODE_ALE = 6'h9;

    localparam int INT_W         = 13;
    localparam int HW_INT_W      = 8;
    localparam int SW_INT_W      = 2;
    localparam int TIMER_INT_BIT = 11;

    // count value of a stopped timer
    localparam logic [31:0] TIMER_IDLE = 32'hffff_ffff;

endpackage

// ==== logic/csr_access_ctrl.sv ====
`timescale 1ns/10ps

module csr_access_ctrl (
    input  logic                                csr_re,
    input  logic [csr_addr_pkg::CSR_NUM_W-1:0]  csr_num,
    input  logic                                csr_we,
    input  logic [csr_addr_pkg::CSR_DATA_W-1:0] csr_wmask,
    input  logic [csr_addr_pkg::CSR_DATA_W-1:0] csr_wvalue,
    input  logic [csr_addr_pkg::CSR_DATA_W-1:0] crmd,
    input  logic [csr_addr_pkg::CSR_DATA_W-1:0] prmd,
    input  logic [csr_addr_pkg::CSR_DATA_W-1:0] ecfg,
    input  logic [csr_addr_pkg::CSR_DATA_W-1:0] estat,
    input  logic [csr_addr_pkg::CSR_DATA_W-1:0] era,
    input  logic [csr_addr_pkg::CSR_DATA_W-1:0] badv,
    input  logic [csr_addr_pkg::CSR_DATA_W-1:0] eentry,
    input  logic [csr_addr_pkg::CSR_DATA_W-1:0] save0,
    input  logic [csr_addr_pkg::CSR_DATA_W-1:0] save1,
    input  logic [csr_addr_pkg::CSR_DATA_W-1:0] save2,
    input  logic [csr_addr_pkg::CSR_DATA_W-1:0] save3,
    input  logic [csr_addr_pkg::CSR_DATA_W-1:0] tcfg,
    input  logic [csr_addr_pkg::CSR_DATA_W-1:0] tval,
    output logic                                crmd_we,
    output logic                                prmd_we,
    output logic                                ecfg_we,
    output logic                                estat_we,
    output logic                                era_we,
    output logic                                badv_we,
    output logic                                eentry_we,
    output logic [3:0]                          save_we,
    output logic                                tcfg_we,
    output logic                                ticlr_we,
    output logic [csr_addr_pkg::CSR_DATA_W-1:0] csr_wdata,
    output logic [csr_addr_pkg::CSR_DATA_W-1:0] csr_rvalue
);

    import csr_addr_pkg::*;
    import csr_exc_pkg::*;

    logic [CSR_DATA_W-1:0] cur_word;

    // ticlr and unknown numbers fall to zero
    always_comb
    begin
        case (csr_num)
            CSR_CRMD:   cur_word = crmd;
            CSR_PRMD:   cur_word = prmd;
            CSR_ECFG:   cur_word = ecfg;
            CSR_ESTAT:  cur_word = estat;
            CSR_ERA:    cur_word = era;
            CSR_BADV:   cur_word = badv;
            CSR_EENTRY: cur_word = eentry;
            CSR_SAVE0:  cur_word = save0;
            CSR_SAVE1:  cur_word = save1;
            CSR_SAVE2:  cur_word = save2;
            CSR_SAVE3:  cur_word = save3;
            CSR_TCFG:   cur_word = tcfg;
            CSR_TVAL:   cur_word = tval;
            default:    cur_word = '0;
        endcase
    end

    assign csr_rvalue = csr_re ? cur_word : '0;

    // unmasked bits keep the register's current value
    assign csr_wdata = (csr_wmask & csr_wvalue) | (~csr_wmask & cur_word);

    assign crmd_we   = csr_we && (csr_num == CSR_CRMD);
    assign prmd_we   = csr_we && (csr_num == CSR_PRMD);
    assign ecfg_we   = csr_we && (csr_num == CSR_ECFG);
    assign estat_we  = csr_we && (csr_num == CSR_ESTAT);
    assign era_we    = csr_we && (csr_num == CSR_ERA);
    assign badv_we   = csr_we && (csr_num == CSR_BADV);
    assign eentry_we = csr_we && (csr_num == CSR_EENTRY);
    assign tcfg_we   = csr_we && (csr_num == CSR_TCFG);
    assign ticlr_we  = csr_we && (csr_num == CSR_TICLR);
    assign save_we   = {4{csr_we}} & {csr_num == CSR_SAVE3, csr_num == CSR_SAVE2,
                                      csr_num == CSR_SAVE1, csr_num == CSR_SAVE0};

endmodule

// ==== logic/privilege_mode_regs.sv ====
`timescale 1ns/10ps

module privilege_mode_regs (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                wb_ex,
    input  logic                                ertn_flush,
    input  logic                                crmd_we,
    input  logic                                prmd_we,
    input  logic [csr_addr_pkg::CSR_DATA_W-1:0] csr_wdata,
    output logic [csr_addr_pkg::CSR_DATA_W-1:0] crmd,
    output logic [csr_addr_pkg::CSR_DATA_W-1:0] prmd,
    output logic                                crmd_ie
);

    import csr_addr_pkg::*;
    import csr_exc_pkg::*;

    // crmd: plv [1:0], ie [2], da [3], pg [4], datf [6:5], datm [8:7]
    logic [CRMD_W-1:0] crmd_q;
    // prmd: pplv [1:0], pie [2], same layout as the low crmd bits
    logic [PRMD_W-1:0] prmd_q;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            crmd_q <= CRMD_W'(8);   // direct address mode
        end
        else if (wb_ex)
        begin
            crmd_q[PRMD_W-1:0] <= '0;
        end
        else if (ertn_flush)
        begin
            crmd_q[PRMD_W-1:0] <= prmd_q;
        end
        else if (crmd_we)
        begin
            crmd_q <= csr_wdata[CRMD_W-1:0];
        end
    end

    always_ff @(posedge clk)
    begin
        if (wb_ex)
        begin
            prmd_q <= crmd_q[PRMD_W-1:0];
        end
        else if (prmd_we)
        begin
            prmd_q <= csr_wdata[PRMD_W-1:0];
        end
    end

    assign crmd    = {{(CSR_DATA_W-CRMD_W){1'b0}}, crmd_q};
    assign prmd    = {{(CSR_DATA_W-PRMD_W){1'b0}}, prmd_q};
    assign crmd_ie = crmd_q[2];

    // the pipeline retires an exception and an ertn on different cycles
    assert property (@(posedge clk) disable iff (reset) !(wb_ex && ertn_flush))
        else $error("privilege_mode_regs: wb_ex and ertn_flush together");

endmodule

// ==== logic/exception_state_regs.sv ====
`timescale 1ns/10ps

module exception_state_regs (
    input  logic                                clk,
    input  logic                                wb_ex,
    input  logic [csr_exc_pkg::ECODE_W-1:0]     wb_ecode,
    input  logic [csr_exc_pkg::ESUBCODE_W-1:0]  wb_esubcode,
    input  logic [csr_addr_pkg::CSR_DATA_W-1:0] wb_pc,
    input  logic [csr_addr_pkg::CSR_DATA_W-1:0] wb_vaddr,
    input  logic [csr_exc_pkg::INT_W-1:0]       estat_is,
    input  logic                                era_we,
    input  logic                                badv_we,
    input  logic                                eentry_we,
    input  logic [3:0]                          save_we,
    input  logic [csr_addr_pkg::CSR_DATA_W-1:0] csr_wdata,
    output logic [csr_addr_pkg::CSR_DATA_W-1:0] estat,
    output logic [csr_addr_pkg::CSR_DATA_W-1:0] era,
    output logic [csr_addr_pkg::CSR_DATA_W-1:0] badv,
    output logic [csr_addr_pkg::CSR_DATA_W-1:0] eentry,
    output logic [csr_addr_pkg::CSR_DATA_W-1:0] save0,
    output logic [csr_addr_pkg::CSR_DATA_W-1:0] save1,
    output logic [csr_addr_pkg::CSR_DATA_W-1:0] save2,
    output logic [csr_addr_pkg::CSR_DATA_W-1:0] save3
);

    import csr_addr_pkg::*;
    import csr_exc_pkg::*;

    logic [ECODE_W-1:0]                ecode_q;
    logic [ESUBCODE_W-1:0]             esubcode_q;
    logic [CSR_DATA_W-1:EENTRY_VA_LSB] eentry_va;
    logic [CSR_DATA_W-1:0]             save_q [4];
    logic                              is_adef;
    logic                              addr_err;

    assign is_adef  = (wb_ecode == ECODE_ADE) && (wb_esubcode == '0);
    assign addr_err = is_adef || (wb_ecode == ECODE_ALE);

    always_ff @(posedge clk)
    begin
        if (wb_ex)
        begin
            ecode_q    <= wb_ecode;
            esubcode_q <= wb_esubcode;
            era        <= wb_pc;
        end
        else if (era_we)
        begin
            era <= csr_wdata;
        end
    end

    // fetch errors report the pc, data errors the access address
    always_ff @(posedge clk)
    begin
        if (wb_ex && addr_err)
        begin
            badv <= is_adef ? wb_pc : wb_vaddr;
        end
        else if (badv_we)
        begin
            badv <= csr_wdata;
        end
    end

    always_ff @(posedge clk)
    begin
        if (eentry_we)
        begin
            eentry_va <= csr_wdata[CSR_DATA_W-1:EENTRY_VA_LSB];
        end
        for (int i = 0; i < 4; i++)
        begin
            if (save_we[i])
            begin
                save_q[i] <= csr_wdata;
            end
        end
    end

    always_comb
    begin
        estat = '0;
        estat[INT_W-1:0] = estat_is;
        estat[ESTAT_ECODE_LSB +: ECODE_W] = ecode_q;
        estat[ESTAT_ESUBCODE_LSB +: ESUBCODE_W] = esubcode_q;
    end

    assign eentry = {eentry_va, {EENTRY_VA_LSB{1'b0}}};
    assign save0  = save_q[0];
    assign save1  = save_q[1];
    assign save2  = save_q[2];
    assign save3  = save_q[3];

endmodule

// ==== logic/interrupt_unit.sv ====
`timescale 1ns/10ps

module interrupt_unit (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [csr_exc_pkg::HW_INT_W-1:0]    hw_int_in,
    input  logic                                timer_zero,
    input  logic                                tcfg_en,
    input  logic                                crmd_ie,
    input  logic                                ecfg_we,
    input  logic                                estat_we,
    input  logic                                ticlr_we,
    input  logic [csr_addr_pkg::CSR_DATA_W-1:0] csr_wdata,
    output logic [csr_addr_pkg::CSR_DATA_W-1:0] ecfg,
    output logic [csr_exc_pkg::INT_W-1:0]       estat_is,
    output logic                                has_int
);

    import csr_addr_pkg::*;
    import csr_exc_pkg::*;

    logic [INT_W-1:0]    lie;
    logic [SW_INT_W-1:0] sw_int;
    logic [HW_INT_W-1:0] hw_int;
    logic                timer_int;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            lie       <= '0;
            sw_int    <= '0;
            hw_int    <= '0;
            timer_int <= 1'b0;
        end
        else
        begin
            hw_int <= hw_int_in;
            if (ecfg_we)
            begin
                lie <= csr_wdata[INT_W-1:0];
            end
            if (estat_we)
            begin
                sw_int <= csr_wdata[SW_INT_W-1:0];
            end
            // a new expiry beats a clear in the same cycle
            if (timer_zero && tcfg_en)
            begin
                timer_int <= 1'b1;
            end
            else if (ticlr_we && csr_wdata[0])
            begin
                timer_int <= 1'b0;
            end
        end
    end

    // bit 10 reserved, no ipi on bit 12
    assign estat_is = {1'b0, timer_int, 1'b0, hw_int, sw_int};
    assign ecfg     = {{(CSR_DATA_W-INT_W){1'b0}}, lie[INT_W-1:TIMER_INT_BIT], 1'b0,
                       lie[TIMER_INT_BIT-2:0]};
    assign has_int  = crmd_ie && ((estat_is[TIMER_INT_BIT:0] & lie[TIMER_INT_BIT:0]) != '0);

endmodule

// ==== logic/csr_timer.sv ====
`timescale 1ns/10ps

module csr_timer (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                tcfg_we,
    input  logic [csr_addr_pkg::CSR_DATA_W-1:0] csr_wdata,
    output logic [csr_addr_pkg::CSR_DATA_W-1:0] tcfg,
    output logic [csr_addr_pkg::CSR_DATA_W-1:0] tval,
    output logic                                timer_zero,
    output logic                                tcfg_en
);

    import csr_addr_pkg::*;
    import csr_exc_pkg::*;

    logic                                 en;
    logic                                 periodic;
    logic [CSR_DATA_W-1:TCFG_INITVAL_LSB] initval;
    logic [CSR_DATA_W-1:0]                count;
    logic                                 load;

    // writing tcfg with en set restarts the count
    assign load = tcfg_we && csr_wdata[0];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            en <= 1'b0;
        end
        else if (tcfg_we)
        begin
            en <= csr_wdata[0];
        end
    end

    always_ff @(posedge clk)
    begin
        if (tcfg_we)
        begin
            periodic <= csr_wdata[1];
            initval  <= csr_wdata[CSR_DATA_W-1:TCFG_INITVAL_LSB];
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            count <= TIMER_IDLE;
        end
        else if (load)
        begin
            count <= {csr_wdata[CSR_DATA_W-1:TCFG_INITVAL_LSB], {TCFG_INITVAL_LSB{1'b0}}};
        end
        else if (en && count != TIMER_IDLE)
        begin
            if (timer_zero && periodic)
            begin
                count <= {initval, {TCFG_INITVAL_LSB{1'b0}}};
            end
            else
            begin
                // one-shot wraps from 0 to idle and parks there
                count <= count - 1'b1;
            end
        end
    end

    assign tcfg       = {initval, periodic, en};
    assign tval       = count;
    assign timer_zero = (count == '0);
    assign tcfg_en    = en;

    assert property (@(posedge clk) disable iff (reset) !en && !tcfg_we |=> $stable(count))
        else $error("csr_timer: count moved while disabled");

endmodule

// ==== logic/csr_unit_top.sv ====
`timescale 1ns/10ps

module csr_unit_top (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                csr_re,
    input  logic [csr_addr_pkg::CSR_NUM_W-1:0]  csr_num,
    input  logic                                csr_we,
    input  logic [csr_addr_pkg::CSR_DATA_W-1:0] csr_wmask,
    input  logic [csr_addr_pkg::CSR_DATA_W-1:0] csr_wvalue,
    input  logic                                wb_ex,
    input  logic [csr_exc_pkg::ECODE_W-1:0]     wb_ecode,
    input  logic [csr_exc_pkg::ESUBCODE_W-1:0]  wb_esubcode,
    input  logic [csr_addr_pkg::CSR_DATA_W-1:0] wb_pc,
    input  logic [csr_addr_pkg::CSR_DATA_W-1:0] wb_vaddr,
    input  logic                                ertn_flush,
    input  logic [csr_exc_pkg::HW_INT_W-1:0]    hw_int_in,
    output logic [csr_addr_pkg::CSR_DATA_W-1:0] csr_rvalue,
    output logic [csr_addr_pkg::CSR_DATA_W-1:0] csr_eentry,
    output logic [csr_addr_pkg::CSR_DATA_W-1:0] csr_era,
    output logic                                has_int
);

    import csr_addr_pkg::*;
    import csr_exc_pkg::*;

    logic [CSR_DATA_W-1:0] csr_wdata;
    logic [CSR_DATA_W-1:0] crmd, prmd, ecfg, estat, badv;
    logic [CSR_DATA_W-1:0] save0, save1, save2, save3;
    logic [CSR_DATA_W-1:0] tcfg, tval;
    logic                  crmd_we, prmd_we, ecfg_we, estat_we;
    logic                  era_we, badv_we, eentry_we, tcfg_we, ticlr_we;
    logic [3:0]            save_we;
    logic                  crmd_ie, timer_zero, tcfg_en;
    logic [INT_W-1:0]      estat_is;

    csr_access_ctrl u_access_ctrl (.era(csr_era), .eentry(csr_eentry), .*);

    privilege_mode_regs u_mode_regs (.*);

    exception_state_regs u_exc_regs (.era(csr_era), .eentry(csr_eentry), .*);

    interrupt_unit u_int_unit (.*);

    csr_timer u_timer (.*);

endmodule

// ==== dv/clk_rst_gen.sv ====
`timescale 1ns/10ps

module clk_rst_gen (
    output logic clk,
    output logic reset
);

    localparam int HALF_PERIOD_NS = 5;
    localparam int RESET_CYCLES   = 2;

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(HALF_PERIOD_NS) clk = ~clk;
        end
    end

    // synchronous reset, released on a rising edge
    initial
    begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// ==== dv/csr_unit_tb.sv ====
`timescale 1ns/10ps

module csr_unit_tb;

    import csr_addr_pkg::*;
    import csr_exc_pkg::*;

    // cycle budgets per test, summed for the watchdog
    localparam int MASK_CYCLES  = 200;
    localparam int EXC_CYCLES   = 40;
    localparam int BADV_CYCLES  = 40;
    localparam int INT_CYCLES   = 60;
    localparam int TIMER_CYCLES = 160;
    localparam int SLACK_CYCLES = 100;
    localparam int WATCHDOG_NS  = 10 * (MASK_CYCLES + EXC_CYCLES + BADV_CYCLES + INT_CYCLES
                                        + TIMER_CYCLES + SLACK_CYCLES);

    localparam logic [CSR_DATA_W-1:0] ONES    = 32'hffff_ffff;
    localparam logic [CSR_DATA_W-1:0] IS_MASK = 32'h0000_1fff;

    logic                   clk;
    logic                   reset;
    logic                   csr_re;
    logic [CSR_NUM_W-1:0]   csr_num;
    logic                   csr_we;
    logic [CSR_DATA_W-1:0]  csr_wmask;
    logic [CSR_DATA_W-1:0]  csr_wvalue;
    logic                   wb_ex;
    logic [ECODE_W-1:0]     wb_ecode;
    logic [ESUBCODE_W-1:0]  wb_esubcode;
    logic [CSR_DATA_W-1:0]  wb_pc;
    logic [CSR_DATA_W-1:0]  wb_vaddr;
    logic                   ertn_flush;
    logic [HW_INT_W-1:0]    hw_int_in;
    logic [CSR_DATA_W-1:0]  csr_rvalue;
    logic [CSR_DATA_W-1:0]  csr_eentry;
    logic [CSR_DATA_W-1:0]  csr_era;
    logic                   has_int;
    int                     seed = 39;

    clk_rst_gen u_clk_rst (.clk(clk), .reset(reset));

    csr_unit_top u_dut (.*);

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input logic [CSR_DATA_W-1:0] expected,
                              input logic [CSR_DATA_W-1:0] actual);
        if (actual !== expected)
        begin
            fail_run($sformatf("mismatch at %0t ns: %s expected %h got %h",
                               $time, name, expected, actual));
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            fail_run($sformatf("mismatch at %0t ns: %s expected %b got %b",
                               $time, name, expected, actual));
        end
    endtask

    task automatic csr_write(input logic [CSR_NUM_W-1:0] num, input logic [CSR_DATA_W-1:0] mask,
                             input logic [CSR_DATA_W-1:0] value);
        @(posedge clk);
        csr_we     <= 1'b1;
        csr_num    <= num;
        csr_wmask  <= mask;
        csr_wvalue <= value;
        @(posedge clk);
        csr_we <= 1'b0;
    endtask

    task automatic expect_csr(input string name, input logic [CSR_NUM_W-1:0] num,
                              input logic [CSR_DATA_W-1:0] expected);
        @(posedge clk);
        csr_re  <= 1'b1;
        csr_num <= num;
        @(negedge clk);
        check_word(name, expected, csr_rvalue);
    endtask

    task automatic pulse_exception(input logic [ECODE_W-1:0] ecode,
                                   input logic [ESUBCODE_W-1:0] esub,
                                   input logic [CSR_DATA_W-1:0] pc,
                                   input logic [CSR_DATA_W-1:0] vaddr);
        @(posedge clk);
        wb_ex       <= 1'b1;
        wb_ecode    <= ecode;
        wb_esubcode <= esub;
        wb_pc       <= pc;
        wb_vaddr    <= vaddr;
        @(posedge clk);
        wb_ex <= 1'b0;
    endtask

    task automatic pulse_ertn;
        @(posedge clk);
        ertn_flush <= 1'b1;
        @(posedge clk);
        ertn_flush <= 1'b0;
    endtask

    task automatic test_masked_access;
        logic [CSR_NUM_W-1:0]  nums [7];
        logic [CSR_DATA_W-1:0] keep [7];
        logic [CSR_DATA_W-1:0] model;
        logic [CSR_DATA_W-1:0] mask;
        logic [CSR_DATA_W-1:0] value;
        nums = '{CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3, CSR_ERA, CSR_EENTRY, CSR_ECFG};
        // eentry low bits and ecfg bit 10 read zero
        keep = '{ONES, ONES, ONES, ONES, ONES, 32'hffff_ffc0, 32'h0000_1bff};
        expect_csr("crmd after reset", CSR_CRMD, 32'h8);
        expect_csr("ecfg after reset", CSR_ECFG, 32'h0);
        expect_csr("tval after reset", CSR_TVAL, TIMER_IDLE);
        for (int r = 0; r < 7; r++)
        begin
            model = 32'h0;
            for (int w = 0; w < 5; w++)
            begin
                // first write sets every bit so no unknown old bits remain
                mask  = (w == 0) ? ONES : $random(seed);
                value = $random(seed);
                model = ((mask & value) | (~mask & model)) & keep[r];
                csr_write(nums[r], mask, value);
                expect_csr($sformatf("csr 0x%0h", nums[r]), nums[r], model);
                if (nums[r] == CSR_EENTRY)
                begin
                    check_word("csr_eentry", model, csr_eentry);
                end
            end
        end
        expect_csr("unknown csr 0x2", 14'h2, 32'h0);
        expect_csr("ticlr read", CSR_TICLR, 32'h0);
        expect_csr("unknown csr 0x3fff", 14'h3fff, 32'h0);
        @(posedge clk);
        csr_re  <= 1'b0;
        csr_num <= CSR_SAVE0;
        @(negedge clk);
        check_word("csr_rvalue with csr_re low", 32'h0, csr_rvalue);
    endtask

    task automatic test_exception_return;
        logic [CSR_DATA_W-1:0] pc;
        logic [ESUBCODE_W-1:0] esub;
        logic [ECODE_W-1:0]    ecode;
        pc    = $random(seed);
        esub  = ESUBCODE_W'($random(seed));
        ecode = 6'h0b;
        csr_write(CSR_CRMD, 32'h7, 32'h7);
        expect_csr("crmd plv 3 ie 1", CSR_CRMD, 32'hf);
        pulse_exception(ecode, esub, pc, 32'h0);
        expect_csr("crmd after exception", CSR_CRMD, 32'h8);
        expect_csr("prmd after exception", CSR_PRMD, 32'h7);
        check_word("csr_era", pc, csr_era);
        expect_csr("estat codes", CSR_ESTAT, (CSR_DATA_W'(esub) << ESTAT_ESUBCODE_LSB)
                                             | (CSR_DATA_W'(ecode) << ESTAT_ECODE_LSB));
        pulse_ertn();
        expect_csr("crmd after ertn", CSR_CRMD, 32'hf);
    endtask

    task automatic test_badv_capture;
        logic [CSR_DATA_W-1:0] pc;
        logic [CSR_DATA_W-1:0] vaddr;
        pc    = $random(seed);
        vaddr = $random(seed);
        pulse_exception(ECODE_ADE, '0, pc, vaddr);
        expect_csr("badv after adef", CSR_BADV, pc);
        pc    = $random(seed);
        vaddr = $random(seed);
        pulse_exception(ECODE_ALE, ESUBCODE_W'($random(seed)), pc, vaddr);
        expect_csr("badv after ale", CSR_BADV, vaddr);
        pulse_exception(6'h0b, '0, $random(seed), $random(seed));
        expect_csr("badv after other ecode", CSR_BADV, vaddr);
    endtask

    task automatic test_interrupt_gating;
        csr_write(CSR_CRMD, 32'h4, 32'h0);
        csr_write(CSR_ECFG, ONES, 32'h0);
        csr_write(CSR_ESTAT, 32'h3, 32'h1);
        @(negedge clk);
        check_bit("has_int with lie clear", 1'b0, has_int);
        csr_write(CSR_ECFG, ONES, 32'h1);
        @(negedge clk);
        check_bit("has_int with ie clear", 1'b0, has_int);
        csr_write(CSR_CRMD, 32'h4, 32'h4);
        @(negedge clk);
        check_bit("has_int software bit", 1'b1, has_int);
        csr_write(CSR_ECFG, ONES, 32'h2);
        @(negedge clk);
        check_bit("has_int other lie bit", 1'b0, has_int);
        csr_write(CSR_ESTAT, 32'h3, 32'h0);
        csr_write(CSR_ECFG, ONES, 32'h0);
        @(posedge clk);
        hw_int_in <= 8'h04;
        csr_re    <= 1'b1;
        csr_num   <= CSR_ESTAT;
        @(negedge clk);
        check_word("estat.is before hw sample", 32'h0, csr_rvalue & IS_MASK);
        @(negedge clk);
        check_word("estat.is after hw sample", 32'h10, csr_rvalue & IS_MASK);
        check_bit("has_int hw without lie", 1'b0, has_int);
        csr_write(CSR_ECFG, ONES, 32'h10);
        @(negedge clk);
        check_bit("has_int hw line", 1'b1, has_int);
        @(posedge clk);
        hw_int_in <= 8'h00;
        @(negedge clk);
        check_bit("has_int hw held one cycle", 1'b1, has_int);
        @(negedge clk);
        check_bit("has_int hw released", 1'b0, has_int);
    endtask

    task automatic test_timer;
        int                    period;
        logic                  seen;
        logic [CSR_DATA_W-1:0] tcfg_word;
        period = 3 * 4;
        seen   = 1'b0;
        csr_write(CSR_ECFG, ONES, 32'h800);
        csr_write(CSR_CRMD, 32'h4, 32'h4);
        tcfg_word = (32'd3 << TCFG_INITVAL_LSB) | 32'h3;
        csr_write(CSR_TCFG, ONES, tcfg_word);
        csr_re  <= 1'b1;
        csr_num <= CSR_TVAL;
        // n counts edges after the tcfg write edge
        for (int n = 0; n <= period + 1; n++)
        begin
            @(negedge clk);
            check_word("tval", (n <= period) ? CSR_DATA_W'(period - n) : CSR_DATA_W'(period),
                       csr_rvalue);
            check_bit("has_int from timer", n == period + 1, has_int);
        end
        // ticlr lands two edges after the rise, the next rise is one period after it
        csr_write(CSR_TICLR, ONES, 32'h1);
        csr_num <= CSR_ESTAT;
        for (int k = 0; k <= period - 1; k++)
        begin
            @(negedge clk);
            check_bit("estat.is[11] periodic", k == period - 1, csr_rvalue[TIMER_INT_BIT]);
        end
        csr_write(CSR_TCFG, ONES, (32'd2 << TCFG_INITVAL_LSB) | 32'h1);
        csr_write(CSR_TICLR, ONES, 32'h1);
        csr_num <= CSR_ESTAT;
        for (int i = 0; i < 20 && !seen; i++)
        begin
            @(negedge clk);
            seen = csr_rvalue[TIMER_INT_BIT];
        end
        if (!seen)
        begin
            fail_run("one-shot timer never raised estat.is[11]");
        end
        expect_csr("tval after one-shot", CSR_TVAL, TIMER_IDLE);
        csr_write(CSR_TICLR, ONES, 32'h1);
        repeat (2 * period) @(posedge clk);
        // ecode of the last exception is still held
        expect_csr("estat after one-shot clear", CSR_ESTAT,
                   CSR_DATA_W'(6'h0b) << ESTAT_ECODE_LSB);
        expect_csr("tval stays idle", CSR_TVAL, TIMER_IDLE);
    endtask

    initial
    begin
        #(WATCHDOG_NS);
        fail_run("watchdog timeout, tests did not finish in time");
    end

    initial
    begin
        csr_re      = 1'b0;
        csr_num     = '0;
        csr_we      = 1'b0;
        csr_wmask   = '0;
        csr_wvalue  = '0;
        wb_ex       = 1'b0;
        wb_ecode    = '0;
        wb_esubcode = '0;
        wb_pc       = '0;
        wb_vaddr    = '0;
        ertn_flush  = 1'b0;
        hw_int_in   = '0;
        wait (reset === 1'b0);
        test_masked_access();
        test_exception_return();
        test_badv_capture();
        test_interrupt_gating();
        test_timer();
        $display("sim passed");
        $finish;
    end

endmodule

// ==== build.f ====
common/csr_addr_pkg.sv
common/csr_exc_pkg.sv
logic/csr_access_ctrl.sv
logic/privilege_mode_regs.sv
logic/exception_state_regs.sv
logic/interrupt_unit.sv
logic/csr_timer.sv
logic/csr_unit_top.sv
dv/clk_rst_gen.sv
dv/csr_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the CSR unit testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module csr_unit_tb -f build.f -o csr_unit_sim

# the exit code of the simulator is hidden by tee, the log decides
./obj_dir/csr_unit_sim 2>&1 | tee sim.log

if grep -q "sim failed" sim.log; then
    exit 1
fi
if ! grep -q "sim passed" sim.log; then
    exit 1
fi
exit 0
